// File: cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

   // Bus widths
   localparam int axi_addr_w = 32;
   localparam int axi_data_w = 64;
   localparam int axi_strb_w = 8;                       // One strobe per data byte
   localparam int axi_tag_w  = 3;                       // ID width seen by each source
   localparam int axi_id_w   = 4;                       // Tag plus one source bit
   localparam int axi_len_w  = 8;

   // Source numbering inside the SoC-side ID
   localparam logic src_ibus = 1'b0;
   localparam logic src_dbus = 1'b1;

   typedef logic [axi_tag_w-1:0] axi_tag_t;

   typedef struct packed {
      logic     src;                                    // Issuing CPU port
      axi_tag_t tag;                                    // Source's own ID
   } axi_id_fields_t;

   // SoC-side ID, read either as a plain word or split into source and tag
   typedef union packed {
      logic [axi_id_w-1:0] raw;
      axi_id_fields_t      fld;
   } axi_id_u;

   typedef struct packed {
      logic [axi_addr_w-1:0] addr;
      axi_tag_t              tag;
      logic [axi_len_w-1:0]  len;                       // Beats minus one
      logic [2:0]            size;
      logic [1:0]            burst;
   } axi_ar_src_t;

   typedef struct packed {
      logic [axi_addr_w-1:0] addr;
      axi_id_u               id;
      logic [axi_len_w-1:0]  len;
      logic [2:0]            size;
      logic [1:0]            burst;
   } axi_ar_t;

   typedef struct packed {
      logic [axi_data_w-1:0] data;
      axi_tag_t              tag;
      logic [1:0]            resp;
      logic                  last;                      // Final beat of the burst
   } axi_r_src_t;

   typedef struct packed {
      logic [axi_data_w-1:0] data;
      axi_id_u               id;
      logic [1:0]            resp;
      logic                  last;
   } axi_r_t;

   typedef struct packed {
      logic [axi_addr_w-1:0] addr;
      axi_tag_t              tag;
      logic [axi_len_w-1:0]  len;
      logic [2:0]            size;
      logic [1:0]            burst;
   } axi_aw_src_t;

   typedef struct packed {
      logic [axi_addr_w-1:0] addr;
      axi_id_u               id;
      logic [axi_len_w-1:0]  len;
      logic [2:0]            size;
      logic [1:0]            burst;
   } axi_aw_t;

   typedef struct packed {
      logic [axi_data_w-1:0] data;
      logic [axi_strb_w-1:0] strb;
      logic                  last;
   } axi_w_t;

   typedef struct packed {
      axi_tag_t   tag;
      logic [1:0] resp;
   } axi_b_src_t;

   typedef struct packed {
      axi_id_u    id;
      logic [1:0] resp;
   } axi_b_t;

endpackage

`default_nettype wire

// File: axi_ar_arbiter.sv
`default_nettype none

module axi_ar_arbiter (
   input  wire logic                     clock,
   input  wire logic                     rst,

   // Instruction bus read address
   input  wire logic                     ibus_ar_valid,
   output logic                          ibus_ar_ready,
   input  wire cpu_bus_pkg::axi_ar_src_t ibus_ar,

   // Data bus read address
   input  wire logic                     dbus_ar_valid,
   output logic                          dbus_ar_ready,
   input  wire cpu_bus_pkg::axi_ar_src_t dbus_ar,

   // Registered SoC read address
   output logic                          m_ar_valid,
   input  wire logic                     m_ar_ready,
   output cpu_bus_pkg::axi_ar_t          m_ar
);

   import cpu_bus_pkg::*;

   logic        stage_full;                             // Output register holds a request
   logic        ar_enable;                              // Low in the first cycle after reset
   logic        last_src;                               // Source granted most recently
   logic        can_load;
   logic        grant_ibus;
   logic        grant_dbus;
   logic        ibus_take;
   logic        dbus_take;
   logic        win_src;
   axi_ar_src_t win_ar;

   // Stage frees in the same cycle the SoC takes its request
   assign can_load = ar_enable && (!stage_full || m_ar_ready);

   // Round robin, on a tie the source not granted last wins
   assign grant_ibus = ibus_ar_valid && (!dbus_ar_valid || (last_src == src_dbus));
   assign grant_dbus = dbus_ar_valid && (!ibus_ar_valid || (last_src == src_ibus));

   // The losing source sees ready low and keeps its request waiting
   assign ibus_ar_ready = can_load && !grant_dbus;
   assign dbus_ar_ready = can_load && !grant_ibus;

   assign ibus_take = ibus_ar_valid && ibus_ar_ready;
   assign dbus_take = dbus_ar_valid && dbus_ar_ready;

   assign win_src = dbus_take ? src_dbus : src_ibus;
   assign win_ar  = dbus_take ? dbus_ar : ibus_ar;

   assign m_ar_valid = stage_full;

   always_ff @(posedge clock) begin
      if (rst) begin
         stage_full <= 1'b0;
         ar_enable  <= 1'b0;
         last_src   <= src_dbus;                        // So ibus wins the first tie
      end else begin
         ar_enable <= 1'b1;
         if (ibus_take || dbus_take) begin
            stage_full <= 1'b1;
            last_src   <= win_src;
         end else if (m_ar_ready) begin
            stage_full <= 1'b0;                         // Drained, nothing new
         end
      end
   end

   // Request payload, loaded only on a source handshake
   always_ff @(posedge clock) begin
      if (ibus_take || dbus_take) begin
         m_ar.addr       <= win_ar.addr;
         m_ar.id.fld.src <= win_src;                    // Tag goes under the source bit
         m_ar.id.fld.tag <= win_ar.tag;
         m_ar.len        <= win_ar.len;
         m_ar.size       <= win_ar.size;
         m_ar.burst      <= win_ar.burst;
      end
   end

endmodule

`default_nettype wire

// File: axi_r_router.sv
`default_nettype none

module axi_r_router (
   // SoC read data
   input  wire logic                  m_r_valid,
   output logic                       m_r_ready,
   input  wire cpu_bus_pkg::axi_r_t   m_r,

   // Instruction bus read data
   output logic                       ibus_r_valid,
   input  wire logic                  ibus_r_ready,
   output cpu_bus_pkg::axi_r_src_t    ibus_r,

   // Data bus read data
   output logic                       dbus_r_valid,
   input  wire logic                  dbus_r_ready,
   output cpu_bus_pkg::axi_r_src_t    dbus_r
);

   import cpu_bus_pkg::*;

   logic       to_dbus;                                 // Beat belongs to the data bus
   axi_r_src_t beat;

   assign to_dbus = (m_r.id.fld.src == src_dbus);

   // Same stripped beat goes to both, only valid is steered
   always_comb begin
      beat.data = m_r.data;
      beat.tag  = m_r.id.fld.tag;                       // Bare tag back to the source
      beat.resp = m_r.resp;
      beat.last = m_r.last;
   end

   assign ibus_r = beat;
   assign dbus_r = beat;

   assign ibus_r_valid = m_r_valid && !to_dbus;
   assign dbus_r_valid = m_r_valid && to_dbus;

   // Back-pressure comes only from the addressed source
   assign m_r_ready = to_dbus ? dbus_r_ready : ibus_r_ready;

endmodule

`default_nettype wire

// File: cpu_axi_bridge.sv
`default_nettype none

module cpu_axi_bridge (
   input  wire logic                     clock,
   input  wire logic                     rst,

   // Instruction bus, read only
   input  wire logic                     ibus_ar_valid,
   output logic                          ibus_ar_ready,
   input  wire cpu_bus_pkg::axi_ar_src_t ibus_ar,
   output logic                          ibus_r_valid,
   input  wire logic                     ibus_r_ready,
   output cpu_bus_pkg::axi_r_src_t       ibus_r,

   // Data bus
   input  wire logic                     dbus_ar_valid,
   output logic                          dbus_ar_ready,
   input  wire cpu_bus_pkg::axi_ar_src_t dbus_ar,
   output logic                          dbus_r_valid,
   input  wire logic                     dbus_r_ready,
   output cpu_bus_pkg::axi_r_src_t       dbus_r,
   input  wire logic                     dbus_aw_valid,
   output logic                          dbus_aw_ready,
   input  wire cpu_bus_pkg::axi_aw_src_t dbus_aw,
   input  wire logic                     dbus_w_valid,
   output logic                          dbus_w_ready,
   input  wire cpu_bus_pkg::axi_w_t      dbus_w,
   output logic                          dbus_b_valid,
   input  wire logic                     dbus_b_ready,
   output cpu_bus_pkg::axi_b_src_t       dbus_b,

   // SoC master port
   output logic                          m_ar_valid,
   input  wire logic                     m_ar_ready,
   output cpu_bus_pkg::axi_ar_t          m_ar,
   input  wire logic                     m_r_valid,
   output logic                          m_r_ready,
   input  wire cpu_bus_pkg::axi_r_t      m_r,
   output logic                          m_aw_valid,
   input  wire logic                     m_aw_ready,
   output cpu_bus_pkg::axi_aw_t          m_aw,
   output logic                          m_w_valid,
   input  wire logic                     m_w_ready,
   output cpu_bus_pkg::axi_w_t           m_w,
   input  wire logic                     m_b_valid,
   output logic                          m_b_ready,
   input  wire cpu_bus_pkg::axi_b_t      m_b
);

   import cpu_bus_pkg::*;

   axi_ar_arbiter u_ar_arbiter (
      .clock         (clock),
      .rst           (rst),
      .ibus_ar_valid (ibus_ar_valid),
      .ibus_ar_ready (ibus_ar_ready),
      .ibus_ar       (ibus_ar),
      .dbus_ar_valid (dbus_ar_valid),
      .dbus_ar_ready (dbus_ar_ready),
      .dbus_ar       (dbus_ar),
      .m_ar_valid    (m_ar_valid),
      .m_ar_ready    (m_ar_ready),
      .m_ar          (m_ar)
   );

   axi_r_router u_r_router (
      .m_r_valid    (m_r_valid),
      .m_r_ready    (m_r_ready),
      .m_r          (m_r),
      .ibus_r_valid (ibus_r_valid),
      .ibus_r_ready (ibus_r_ready),
      .ibus_r       (ibus_r),
      .dbus_r_valid (dbus_r_valid),
      .dbus_r_ready (dbus_r_ready),
      .dbus_r       (dbus_r)
   );

   // Only the data bus writes, so its channels go straight through
   assign m_aw_valid    = dbus_aw_valid;
   assign dbus_aw_ready = m_aw_ready;

   always_comb begin
      m_aw.addr       = dbus_aw.addr;
      m_aw.id.fld.src = src_dbus;                       // Widen the tag to a SoC ID
      m_aw.id.fld.tag = dbus_aw.tag;
      m_aw.len        = dbus_aw.len;
      m_aw.size       = dbus_aw.size;
      m_aw.burst      = dbus_aw.burst;
   end

   assign m_w_valid    = dbus_w_valid;
   assign dbus_w_ready = m_w_ready;
   assign m_w          = dbus_w;

   assign dbus_b_valid = m_b_valid;
   assign m_b_ready    = dbus_b_ready;

   always_comb begin
      dbus_b.tag  = m_b.id.raw[axi_tag_w-1:0];          // Low bits carry the tag
      dbus_b.resp = m_b.resp;
   end

endmodule

`default_nettype wire

// File: cpu_axi_bridge_chk.sv
`default_nettype none

module cpu_axi_bridge_chk (
   input wire logic                 clock,
   input wire logic                 rst,
   input wire logic                 m_ar_valid,
   input wire logic                 m_ar_ready,
   input wire cpu_bus_pkg::axi_ar_t m_ar,
   input wire logic                 ibus_r_valid,
   input wire logic                 dbus_r_valid,
   input wire logic                 m_aw_valid,
   input wire cpu_bus_pkg::axi_aw_t m_aw
);

   import cpu_bus_pkg::*;

   int fail_cnt = 0;                                    // Assertion failures so far

   ar_idle_after_reset: assert property (@(posedge clock) $past(rst) |-> !m_ar_valid)
      else begin
         $error("m_ar_valid high right after reset");
         fail_cnt++;
      end

   // AR request must hold until the SoC takes it
   ar_stable: assert property (@(posedge clock) disable iff (rst)
      m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
      else begin
         $error("m_ar changed while waiting for m_ar_ready");
         fail_cnt++;
      end

   r_one_hot: assert property (@(posedge clock) disable iff (rst)
      !(ibus_r_valid && dbus_r_valid))
      else begin
         $error("read data steered to both buses");
         fail_cnt++;
      end

   aw_src: assert property (@(posedge clock) disable iff (rst)
      m_aw_valid |-> m_aw.id.fld.src == src_dbus)
      else begin
         $error("write ID without the data bus source bit");
         fail_cnt++;
      end

endmodule

bind cpu_axi_bridge cpu_axi_bridge_chk u_chk (
   .clock        (clock),
   .rst          (rst),
   .m_ar_valid   (m_ar_valid),
   .m_ar_ready   (m_ar_ready),
   .m_ar         (m_ar),
   .ibus_r_valid (ibus_r_valid),
   .dbus_r_valid (dbus_r_valid),
   .m_aw_valid   (m_aw_valid),
   .m_aw         (m_aw)
);

`default_nettype wire

// File: cpu_axi_bridge_tb.sv
`default_nettype none

module cpu_axi_bridge_tb;

   import cpu_bus_pkg::*;

   typedef struct packed {
      logic [3:0]  test;
      logic [3:0]  kind;                                // 0 read, 1 write
      logic [3:0]  src;
      logic [31:0] addr;
      logic [3:0]  tag;
      logic [7:0]  len;
      logic [7:0]  order;                               // Expected SoC-side position
      logic [63:0] data;
   } gold_t;

   logic clock, rst;
   logic ibus_ar_valid, ibus_ar_ready, ibus_r_valid, ibus_r_ready;
   logic dbus_ar_valid, dbus_ar_ready, dbus_r_valid, dbus_r_ready;
   logic dbus_aw_valid, dbus_aw_ready, dbus_w_valid, dbus_w_ready, dbus_b_valid, dbus_b_ready;
   logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready, m_aw_valid, m_aw_ready;
   logic m_w_valid, m_w_ready, m_b_valid, m_b_ready;
   axi_ar_src_t ibus_ar, dbus_ar;
   axi_r_src_t  ibus_r, dbus_r;
   axi_aw_src_t dbus_aw;
   axi_w_t      dbus_w, m_w;
   axi_b_src_t  dbus_b;
   axi_ar_t     m_ar;
   axi_r_t      m_r;
   axi_aw_t     m_aw;
   axi_b_t      m_b;

   logic [127:0] gold_raw [0:63];
   gold_t   gold [0:63];
   int      n_gold, cur_test, errors, cycles, limit;
   int      ar_pos, aw_pos, w_pos, b_pos, beats_seen, ibus_beats, dbus_beats;
   int      beat_cnt [0:63];
   axi_ar_t rd_pend [$];
   axi_id_u b_pend [$];

   cpu_axi_bridge u_cpu_axi_bridge (.*);

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Round robin restarts from ibus after every reset
   task automatic apply_reset();
      @(negedge clock);
      rst = 1'b1;
      repeat (3) @(posedge clock);
      @(negedge clock);
      rst = 1'b0;
   endtask

   // Entry of the current test with a given kind and expected position
   function automatic int find_by_order(input int kind, input int pos);
      for (int i = 0; i < n_gold; i++)
         if (gold[i].test == cur_test && gold[i].kind == kind && gold[i].order == pos)
            return i;
      return -1;
   endfunction

   function automatic int find_read(input int src, input int tag);
      for (int i = 0; i < n_gold; i++)
         if (gold[i].test == cur_test && gold[i].kind == 0 && gold[i].src == src &&
             gold[i].tag == tag)
            return i;
      return -1;
   endfunction

   task automatic drive_reads(input int src);
      for (int i = 0; i < n_gold; i++) begin
         if (gold[i].test == cur_test && gold[i].kind == 0 && gold[i].src == src) begin
            @(negedge clock);
            if (src == 0) begin
               ibus_ar_valid = 1'b1;
               ibus_ar = '{gold[i].addr, gold[i].tag[2:0], gold[i].len, 3'd3, 2'b01};
               do @(posedge clock); while (!ibus_ar_ready);
            end else begin
               dbus_ar_valid = 1'b1;
               dbus_ar = '{gold[i].addr, gold[i].tag[2:0], gold[i].len, 3'd3, 2'b01};
               do @(posedge clock); while (!dbus_ar_ready);
            end
         end
      end
      @(negedge clock);
      if (src == 0) ibus_ar_valid = 1'b0;
      else dbus_ar_valid = 1'b0;
   endtask

   task automatic drive_writes();
      for (int i = 0; i < n_gold; i++) begin
         if (gold[i].test == cur_test && gold[i].kind == 1) begin
            @(negedge clock);
            dbus_aw_valid = 1'b1;
            dbus_w_valid  = 1'b1;
            dbus_aw = '{gold[i].addr, gold[i].tag[2:0], 8'd0, 3'd3, 2'b01};
            dbus_w  = '{gold[i].data, 8'hff, 1'b1};
            do @(posedge clock); while (!(dbus_aw_ready && dbus_w_ready));
         end
      end
      @(negedge clock);
      dbus_aw_valid = 1'b0;
      dbus_w_valid  = 1'b0;
   endtask

   task automatic handle_beat(input int src, input axi_r_src_t beat);
      int idx;
      idx = find_read(src, beat.tag);
      beats_seen++;
      if (src == 0) ibus_beats++;
      else dbus_beats++;
      if (idx < 0) begin
         $display("read beat on source %0d with unknown tag %0d", src, beat.tag);
         errors++;
      end else begin
         check(beat.data, {gold[idx].addr, 32'(beat_cnt[idx])}, "read data");
         check(beat.last, beat_cnt[idx] == gold[idx].len, "read last");
         check(beat.resp, 2'b00, "read resp");
         beat_cnt[idx]++;
      end
   endtask

   // SoC side monitors
   always @(posedge clock) begin
      int idx;
      if (!rst && m_ar_valid && m_ar_ready) begin
         rd_pend.push_back(m_ar);
         idx = find_by_order(0, ar_pos);
         if (idx < 0) begin
            $display("unexpected read request at SoC port, address %0h", m_ar.addr);
            errors++;
         end else begin
            check(m_ar.id.fld.src, gold[idx].src[0], "ar source bit");
            check(m_ar.id.fld.tag, gold[idx].tag, "ar tag");
            check(m_ar.addr, gold[idx].addr, "ar address");
            check(m_ar.len, gold[idx].len, "ar length");
            check({m_ar.size, m_ar.burst}, {3'd3, 2'b01}, "ar size and burst");
         end
         ar_pos++;
      end
      if (!rst && m_aw_valid && m_aw_ready) begin
         idx = find_by_order(1, aw_pos);
         b_pend.push_back(m_aw.id);
         check(m_aw.addr, gold[idx].addr, "aw address");
         check(m_aw.id.fld.src, src_dbus, "aw source bit");
         check(m_aw.id.fld.tag, gold[idx].tag, "aw tag");
         check({m_aw.len, m_aw.size, m_aw.burst}, {8'd0, 3'd3, 2'b01}, "aw len size burst");
         aw_pos++;
      end
      if (!rst && m_w_valid && m_w_ready) begin
         idx = find_by_order(1, w_pos);
         check(m_w.data, gold[idx].data, "w data");
         check(m_w.strb, 8'hff, "w strobes");
         check(m_w.last, 1'b1, "w last");
         w_pos++;
      end
      if (!rst && ibus_r_valid && ibus_r_ready) handle_beat(0, ibus_r);
      if (!rst && dbus_r_valid && dbus_r_ready) handle_beat(1, dbus_r);
      if (!rst && dbus_b_valid && dbus_b_ready) begin
         idx = find_by_order(1, b_pos);
         check(dbus_b.tag, gold[idx].tag, "b tag");
         check(dbus_b.resp, 2'b00, "b resp");
         b_pos++;
      end
   end

   // Memory model read side, picks any pending burst
   initial begin
      axi_ar_t req;
      int      pick;
      m_r_valid = 1'b0;
      m_r = '0;
      forever begin
         @(negedge clock);
         m_r_valid = 1'b0;
         if (!rst && rd_pend.size() > 0) begin
            pick = $urandom % rd_pend.size();
            req = rd_pend[pick];
            rd_pend.delete(pick);
            for (int b = 0; b <= req.len; b++) begin
               m_r_valid = 1'b1;
               m_r = '{{req.addr, 32'(b)}, req.id, 2'b00, b == req.len};
               do @(posedge clock); while (!m_r_ready);
               if (b != req.len) @(negedge clock);
            end
         end
      end
   end

   // Memory model write response and AR ready gaps
   initial begin
      m_b_valid = 1'b0;
      m_b = '0;
      m_ar_ready = 1'b1;
      forever begin
         @(negedge clock);
         m_ar_ready = (cur_test == 4) ? ($urandom % 3 != 0) : 1'b1;
         m_b_valid = 1'b0;
         if (b_pend.size() > 0) begin
            m_b_valid = 1'b1;
            m_b = '{b_pend.pop_front(), 2'b00};
            do @(posedge clock); while (!m_b_ready);
         end
      end
   end

   initial begin
      @(negedge rst);
      while (cycles < limit) begin
         @(posedge clock);
         cycles++;
      end
      $display("timeout after %0d cycles, test %0d did not complete", cycles, cur_test);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      int exp_ar, exp_wr, exp_beats, exp_i, exp_d, err_before, asrt_before, failed, total_beats;
      string names [1:5];
      names = '{"single ibus read", "simultaneous requests", "out-of-order returns",
                "ar back-pressure", "dbus write"};
      void'($urandom(90));
      rst = 1'b1;
      ibus_ar_valid = 1'b0;
      dbus_ar_valid = 1'b0;
      dbus_aw_valid = 1'b0;
      dbus_w_valid  = 1'b0;
      ibus_ar = '0;
      dbus_ar = '0;
      dbus_aw = '0;
      dbus_w  = '0;
      ibus_r_ready = 1'b1;
      dbus_r_ready = 1'b1;
      dbus_b_ready = 1'b1;
      m_aw_ready = 1'b1;
      m_w_ready  = 1'b1;
      errors = 0;
      failed = 0;
      cycles = 0;
      cur_test = 0;
      $readmemh("cpu_axi_bridge_golden.txt", gold_raw);
      n_gold = 0;
      total_beats = 0;
      while (n_gold < 64 && !$isunknown(gold_raw[n_gold])) begin
         gold[n_gold] = gold_t'(gold_raw[n_gold]);
         total_beats += gold[n_gold].len + 1;
         n_gold++;
      end
      limit = 4 * total_beats + 200;
      for (int t = 1; t <= 5; t++) begin
         cur_test = t;
         err_before = errors;
         asrt_before = u_cpu_axi_bridge.u_chk.fail_cnt;
         apply_reset();
         {ar_pos, aw_pos, w_pos, b_pos, beats_seen, ibus_beats, dbus_beats} = '0;
         {exp_ar, exp_wr, exp_beats, exp_i, exp_d} = '0;
         for (int i = 0; i < n_gold; i++) begin
            beat_cnt[i] = 0;
            if (gold[i].test == t && gold[i].kind == 0) begin
               exp_ar++;
               exp_beats += gold[i].len + 1;
               if (gold[i].src == 0) exp_i += gold[i].len + 1;
               else exp_d += gold[i].len + 1;
            end else if (gold[i].test == t) begin
               exp_wr++;
            end
         end
         fork
            drive_reads(0);
            drive_reads(1);
            drive_writes();
         join
         while (beats_seen < exp_beats || ar_pos < exp_ar || b_pos < exp_wr)
            @(negedge clock);
         check(ibus_beats, exp_i, "ibus beat count");
         check(dbus_beats, exp_d, "dbus beat count");
         check(ar_pos, exp_ar, "ar request count");
         errors += u_cpu_axi_bridge.u_chk.fail_cnt - asrt_before;
         if (errors != err_before) failed++;
         $display("test %0d %s: %s", t, names[t], errors == err_before ? "ok" : "failed");
      end
      $display("tests run 5, failed %0d, errors %0d", failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: cpu_axi_bridge.f
cpu_bus_pkg.sv
axi_ar_arbiter.sv
axi_r_router.sv
cpu_axi_bridge.sv
cpu_axi_bridge_chk.sv
cpu_axi_bridge_tb.sv

// File: cpu_axi_bridge_golden.txt
// test _ kind(0 rd,1 wr) _ src _ addr _ tag _ len _ order _ write data
// order is the position in the SoC-side AR sequence (reads) or AW sequence (writes)
1_0_0_80001000_5_03_00_0000000000000000
2_0_0_80002000_1_01_00_0000000000000000
2_0_1_80002100_3_01_01_0000000000000000
2_0_0_80002200_2_01_02_0000000000000000
2_0_1_80002300_4_01_03_0000000000000000
3_0_0_80003000_0_02_00_0000000000000000
3_0_1_80003100_5_01_01_0000000000000000
3_0_0_80003200_1_00_02_0000000000000000
3_0_1_80003300_6_03_03_0000000000000000
3_0_0_80003400_2_03_04_0000000000000000
3_0_1_80003500_7_00_05_0000000000000000
4_0_0_80004000_1_01_00_0000000000000000
4_0_1_80004100_4_01_01_0000000000000000
4_0_0_80004200_2_01_02_0000000000000000
4_0_1_80004300_5_01_03_0000000000000000
4_0_0_80004400_3_01_04_0000000000000000
5_1_1_40000000_2_00_00_1122334455667788
5_1_1_40000040_6_00_01_a5a5a5a55a5a5a5a
